//--- logic/rv_isa_pkg.sv
package rv_isa_pkg;

    // Datapath and register file geometry
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    ////////////////////////////////////////////////////////////
    // Major opcodes of the base integer set
    ////////////////////////////////////////////////////////////
    localparam logic [6:0] OPC_LUI      = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
    localparam logic [6:0] OPC_JAL      = 7'b1101111;
    localparam logic [6:0] OPC_JALR     = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
    localparam logic [6:0] OPC_LOAD     = 7'b0000011;
    localparam logic [6:0] OPC_STORE    = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_OP       = 7'b0110011;
    localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
    localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

    // Upper function field for plain and alternate ALU forms
    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;

    ////////////////////////////////////////////////////////////
    // Operation codes handed to execute
    ////////////////////////////////////////////////////////////
    // NOP sits at zero so an all-zero bundle reads as a bubble
    typedef enum logic [5:0] {
        NOP,
        LUI,
        ADD, SUB, SLL, SLT, SLTU,
        XOR, SRL, SRA, OR, AND,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        JAL, JALR,
        LB, LH, LW, LBU, LHU,
        SB, SH, SW,
        ECALL, EBREAK, SRET, MRET, WFI,
        CSRRW, CSRRS, CSRRC,
        CSRRWI, CSRRSI, CSRRCI,
        INVALID
    } iType_e;

    typedef enum logic [2:0] {
        R_TYPE,
        I_TYPE,
        S_TYPE,
        B_TYPE,
        U_TYPE,
        J_TYPE
    } formatType_e;

    // Field view of one instruction word, msb first
    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } instr_t;

endpackage

//--- logic/decode_pipe_pkg.sv
package decode_pipe_pkg;

    ////////////////////////////////////////////////////////////
    // Fetch to decode
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        rv_isa_pkg::instr_t          instruction;
        logic [rv_isa_pkg::XLEN-1:0] pc;
    } fetch_bundle_t;

    ////////////////////////////////////////////////////////////
    // Decode to execute
    ////////////////////////////////////////////////////////////
    // Operand meaning depends on the format of the instruction
    typedef struct packed {
        logic [rv_isa_pkg::XLEN-1:0] first_operand;
        logic [rv_isa_pkg::XLEN-1:0] second_operand;
        logic [rv_isa_pkg::XLEN-1:0] third_operand;
        logic [rv_isa_pkg::XLEN-1:0] pc;
        rv_isa_pkg::instr_t          instruction;
        rv_isa_pkg::iType_e          operation;
        // Set when the instruction must not retire
        logic                        killed;
        logic                        exc_illegal;
        logic                        exc_misaligned;
    } issue_bundle_t;

endpackage

//--- logic/instr_classifier.sv
`timescale 1ns/100ps

module instr_classifier (
    input  rv_isa_pkg::instr_t      instruction_i,
    output rv_isa_pkg::iType_e      operation_o,
    output rv_isa_pkg::formatType_e format_o
);
    import rv_isa_pkg::*;

    iType_e op_branch;
    iType_e op_load;
    iType_e op_store;
    iType_e op_imm;
    iType_e op_reg;
    iType_e op_misc_mem;
    iType_e op_system;

    logic [6:0]  funct7;
    logic [2:0]  funct3;
    logic [11:0] funct12;

    assign funct7  = instruction_i.funct7;
    assign funct3  = instruction_i.funct3;
    // Privileged encodings live in the I-type immediate slot
    assign funct12 = {instruction_i.funct7, instruction_i.rs2};

    ////////////////////////////////////////////////////////////
    // Per-class sub-decoders
    ////////////////////////////////////////////////////////////
    always_comb begin
        unique case (funct3)
            3'b000:  op_branch = BEQ;
            3'b001:  op_branch = BNE;
            3'b100:  op_branch = BLT;
            3'b101:  op_branch = BGE;
            3'b110:  op_branch = BLTU;
            3'b111:  op_branch = BGEU;
            default: op_branch = INVALID;
        endcase
    end

    always_comb begin
        unique case (funct3)
            3'b000:  op_load = LB;
            3'b001:  op_load = LH;
            3'b010:  op_load = LW;
            3'b100:  op_load = LBU;
            3'b101:  op_load = LHU;
            default: op_load = INVALID;
        endcase
    end

    always_comb begin
        unique case (funct3)
            3'b000:  op_store = SB;
            3'b001:  op_store = SH;
            3'b010:  op_store = SW;
            default: op_store = INVALID;
        endcase
    end

    // Only the shift forms constrain the upper field
    always_comb begin
        op_imm = INVALID;
        unique case (funct3)
            3'b000: op_imm = ADD;
            3'b001: op_imm = (funct7 == FUNCT7_BASE) ? SLL : INVALID;
            3'b010: op_imm = SLT;
            3'b011: op_imm = SLTU;
            3'b100: op_imm = XOR;
            3'b101: begin
                if (funct7 == FUNCT7_BASE) begin
                    op_imm = SRL;
                end else if (funct7 == FUNCT7_ALT) begin
                    op_imm = SRA;
                end
            end
            3'b110: op_imm = OR;
            3'b111: op_imm = AND;
        endcase
    end

    always_comb begin
        op_reg = INVALID;
        if (funct7 == FUNCT7_BASE) begin
            unique case (funct3)
                3'b000: op_reg = ADD;
                3'b001: op_reg = SLL;
                3'b010: op_reg = SLT;
                3'b011: op_reg = SLTU;
                3'b100: op_reg = XOR;
                3'b101: op_reg = SRL;
                3'b110: op_reg = OR;
                3'b111: op_reg = AND;
            endcase
        end else if (funct7 == FUNCT7_ALT) begin
            if (funct3 == 3'b000) begin
                op_reg = SUB;
            end else if (funct3 == 3'b101) begin
                op_reg = SRA;
            end
        end
    end

    // FENCE has no effect in an in-order single-issue core
    assign op_misc_mem = (funct3 == 3'b000) ? NOP : INVALID;

    always_comb begin
        op_system = INVALID;
        unique case (funct3)
            3'b000: begin
                if (instruction_i.rs1 == '0 && instruction_i.rd == '0) begin
                    unique case (funct12)
                        12'h000: op_system = ECALL;
                        12'h001: op_system = EBREAK;
                        12'h102: op_system = SRET;
                        12'h302: op_system = MRET;
                        12'h105: op_system = WFI;
                        default: op_system = INVALID;
                    endcase
                end
            end
            3'b001: op_system = CSRRW;
            3'b010: op_system = CSRRS;
            3'b011: op_system = CSRRC;
            3'b101: op_system = CSRRWI;
            3'b110: op_system = CSRRSI;
            3'b111: op_system = CSRRCI;
            default: op_system = INVALID;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Opcode select and format
    ////////////////////////////////////////////////////////////
    always_comb begin
        unique case (instruction_i.opcode)
            OPC_LUI:      operation_o = LUI;
            OPC_AUIPC:    operation_o = ADD;
            OPC_JAL:      operation_o = JAL;
            OPC_JALR:     operation_o = JALR;
            OPC_BRANCH:   operation_o = op_branch;
            OPC_LOAD:     operation_o = op_load;
            OPC_STORE:    operation_o = op_store;
            OPC_OP_IMM:   operation_o = op_imm;
            OPC_OP:       operation_o = op_reg;
            OPC_MISC_MEM: operation_o = op_misc_mem;
            OPC_SYSTEM:   operation_o = op_system;
            default:      operation_o = INVALID;
        endcase
    end

    // The low two opcode bits are always 11 and carry no format
    always_comb begin
        unique case (instruction_i.opcode[6:2])
            OPC_JALR[6:2], OPC_LOAD[6:2], OPC_OP_IMM[6:2]: format_o = I_TYPE;
            OPC_STORE[6:2]:                                format_o = S_TYPE;
            OPC_BRANCH[6:2]:                               format_o = B_TYPE;
            OPC_LUI[6:2], OPC_AUIPC[6:2]:                  format_o = U_TYPE;
            OPC_JAL[6:2]:                                  format_o = J_TYPE;
            default:                                       format_o = R_TYPE;
        endcase
    end

endmodule

//--- logic/operand_router.sv
`timescale 1ns/100ps

module operand_router (
    input  rv_isa_pkg::instr_t          instruction_i,
    input  rv_isa_pkg::formatType_e     format_i,
    input  logic [rv_isa_pkg::XLEN-1:0] pc_i,
    input  logic [rv_isa_pkg::XLEN-1:0] rs1_data_i,
    input  logic [rv_isa_pkg::XLEN-1:0] rs2_data_i,
    output logic [rv_isa_pkg::XLEN-1:0] first_operand_o,
    output logic [rv_isa_pkg::XLEN-1:0] second_operand_o,
    output logic [rv_isa_pkg::XLEN-1:0] third_operand_o
);
    import rv_isa_pkg::*;

    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] immediate;
    logic            sign;

    ////////////////////////////////////////////////////////////
    // Immediate assembly
    ////////////////////////////////////////////////////////////
    // Bit 31 of the word is always the immediate sign
    assign sign = instruction_i.funct7[6];

    assign imm_i = {{21{sign}}, instruction_i.funct7[5:0], instruction_i.rs2};
    assign imm_s = {{21{sign}}, instruction_i.funct7[5:0], instruction_i.rd};
    assign imm_b = {{20{sign}}, instruction_i.rd[0], instruction_i.funct7[5:0],
                    instruction_i.rd[4:1], 1'b0};
    assign imm_u = {instruction_i.funct7, instruction_i.rs2, instruction_i.rs1,
                    instruction_i.funct3, 12'b0};
    // J offset bits 19:12 sit in the rs1 and funct3 slots
    assign imm_j = {{12{sign}}, instruction_i.rs1, instruction_i.funct3,
                    instruction_i.rs2[0], instruction_i.funct7[5:0],
                    instruction_i.rs2[4:1], 1'b0};

    always_comb begin
        unique case (format_i)
            I_TYPE:  immediate = imm_i;
            S_TYPE:  immediate = imm_s;
            B_TYPE:  immediate = imm_b;
            U_TYPE:  immediate = imm_u;
            J_TYPE:  immediate = imm_j;
            default: immediate = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Operand routing
    ////////////////////////////////////////////////////////////
    always_comb begin
        first_operand_o  = rs1_data_i;
        second_operand_o = immediate;
        third_operand_o  = immediate;
        unique case (format_i)
            U_TYPE, J_TYPE: first_operand_o = pc_i;
            R_TYPE, B_TYPE: second_operand_o = rs2_data_i;
            // Store data rides in the third slot
            S_TYPE:         third_operand_o = rs2_data_i;
            default: ;
        endcase
    end

endmodule

//--- logic/hazard_unit.sv
`timescale 1ns/100ps

module hazard_unit (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                stall_i,
    input  rv_isa_pkg::instr_t                  instruction_i,
    input  rv_isa_pkg::formatType_e             format_i,
    output rv_isa_pkg::instr_t                  instruction_o,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0]   rd_o,
    output logic                                hazard_o
);
    import rv_isa_pkg::*;

    instr_t                held_instr;
    logic                  replay;
    logic [REG_ADDR_W-1:0] locked_reg;
    logic [REG_ADDR_W-1:0] next_lock;
    logic                  reads_rs1;
    logic                  reads_rs2;
    logic                  rs1_locked;
    logic                  rs2_locked;

    ////////////////////////////////////////////////////////////
    // Replay of the instruction that caused a bubble
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        held_instr <= instruction_o;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            replay <= 1'b0;
        end else begin
            replay <= hazard_o;
        end
    end

    assign instruction_o = replay ? held_instr : instruction_i;

    ////////////////////////////////////////////////////////////
    // Register lock queue
    ////////////////////////////////////////////////////////////
    // A bubble writes nothing
    assign next_lock = hazard_o ? '0 : instruction_o.rd;

    always_ff @(posedge clk) begin
        if (reset) begin
            locked_reg <= '0;
            rd_o       <= '0;
        end else if (!stall_i) begin
            locked_reg <= next_lock;
            rd_o       <= locked_reg;
        end
    end

    // Which source fields the format actually reads
    always_comb begin
        unique case (format_i)
            R_TYPE, B_TYPE, S_TYPE: begin
                reads_rs1 = 1'b1;
                reads_rs2 = 1'b1;
            end
            I_TYPE: begin
                reads_rs1 = 1'b1;
                reads_rs2 = 1'b0;
            end
            default: begin
                reads_rs1 = 1'b0;
                reads_rs2 = 1'b0;
            end
        endcase
    end

    // x0 never carries a dependency
    assign rs1_locked = (instruction_o.rs1 != '0) && (instruction_o.rs1 == locked_reg);
    assign rs2_locked = (instruction_o.rs2 != '0) && (instruction_o.rs2 == locked_reg);

    assign hazard_o = (rs1_locked && reads_rs1) || (rs2_locked && reads_rs2);

endmodule

//--- logic/decode_stage.sv
`timescale 1ns/100ps

module decode_stage (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                stall_i,
    input  logic                                killed_i,
    input  logic                                jumped_i,
    input  decode_pipe_pkg::fetch_bundle_t      fetch_i,
    input  logic [rv_isa_pkg::XLEN-1:0]         rs1_data_i,
    input  logic [rv_isa_pkg::XLEN-1:0]         rs2_data_i,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0]   rs1_o,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0]   rs2_o,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0]   rd_o,
    output decode_pipe_pkg::issue_bundle_t      issue_o,
    output logic                                hazard_o
);
    import rv_isa_pkg::*;
    import decode_pipe_pkg::*;

    instr_t          cur_instr;
    iType_e          operation;
    formatType_e     instr_format;
    logic [XLEN-1:0] first_operand;
    logic [XLEN-1:0] second_operand;
    logic [XLEN-1:0] third_operand;
    issue_bundle_t   issue_next;
    issue_bundle_t   bubble;

    hazard_unit u_hazard (
        .clk           (clk),
        .reset         (reset),
        .stall_i       (stall_i),
        .instruction_i (fetch_i.instruction),
        .format_i      (instr_format),
        .instruction_o (cur_instr),
        .rd_o          (rd_o),
        .hazard_o      (hazard_o)
    );

    instr_classifier u_classifier (
        .instruction_i (cur_instr),
        .operation_o   (operation),
        .format_o      (instr_format)
    );

    operand_router u_router (
        .instruction_i    (cur_instr),
        .format_i         (instr_format),
        .pc_i             (fetch_i.pc),
        .rs1_data_i       (rs1_data_i),
        .rs2_data_i       (rs2_data_i),
        .first_operand_o  (first_operand),
        .second_operand_o (second_operand),
        .third_operand_o  (third_operand)
    );

    // Register file read addresses
    assign rs1_o = cur_instr.rs1;
    assign rs2_o = cur_instr.rs2;

    ////////////////////////////////////////////////////////////
    // Issue register
    ////////////////////////////////////////////////////////////
    always_comb begin
        bubble           = '0;
        bubble.operation = NOP;
    end

    always_comb begin
        issue_next.first_operand  = first_operand;
        issue_next.second_operand = second_operand;
        issue_next.third_operand  = third_operand;
        issue_next.pc             = fetch_i.pc;
        issue_next.instruction    = cur_instr;
        issue_next.operation      = operation;
        issue_next.killed         = killed_i | jumped_i;
        issue_next.exc_illegal    = (operation == INVALID);
        // Instructions are word aligned without the compressed set
        issue_next.exc_misaligned = (fetch_i.pc[1:0] != 2'b00);
    end

    // Hazard wins over stall so the bubble always goes out
    always_ff @(posedge clk) begin
        if (reset) begin
            issue_o <= bubble;
        end else if (hazard_o) begin
            issue_o <= bubble;
        end else if (!stall_i) begin
            issue_o <= issue_next;
        end
    end

endmodule

//--- verification/decode_stage_properties.sv
`timescale 1ns/100ps

module decode_stage_properties (
    input logic                           clk,
    input logic                           reset,
    input logic                           stall_i,
    input logic                           hazard_i,
    input decode_pipe_pkg::issue_bundle_t issue_i
);
    import rv_isa_pkg::*;

    ////////////////////////////////////////////////////////////
    // Issue register behavior
    ////////////////////////////////////////////////////////////
    // A bubble is NOP with every other field cleared
    assert property (@(posedge clk) disable iff (reset)
        hazard_i |=> (issue_i.operation == NOP) && (issue_i == '0))
        else $error("hazard was not followed by a bubble");

    assert property (@(posedge clk) disable iff (reset)
        (stall_i && !hazard_i) |=> (issue_i == $past(issue_i)))
        else $error("issue changed under stall");

    // Lock queue is empty after a reset edge
    assert property (@(posedge clk) reset |=> !hazard_i)
        else $error("hazard raised while in reset");

endmodule

bind decode_stage decode_stage_properties u_properties (
    .clk      (clk),
    .reset    (reset),
    .stall_i  (stall_i),
    .hazard_i (hazard_o),
    .issue_i  (issue_o)
);

//--- verification/decode_stage_tb.sv
`timescale 1ns/100ps

module decode_stage_tb;
    import rv_isa_pkg::*;
    import decode_pipe_pkg::*;

    typedef struct {
        string       name;
        logic [31:0] instr;
        logic [31:0] pc;
        logic        stall;
        logic        kill;
        logic        jump;
        iType_e      op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [2:0]  flags;
        logic        haz;
    } row_t;

    localparam logic [31:0] NOP_WORD = 32'h00000013;
    // Reads its own destination, so a lock left over from reset would raise a hazard
    localparam logic [31:0] RESET_WORD = {FUNCT7_BASE, 5'd5, 5'd5, 3'd0, 5'd5, OPC_OP};

    logic          clk;
    logic          reset;
    logic          stall;
    logic          killed;
    logic          jumped;
    fetch_bundle_t fetch;
    logic [31:0]   rs1_data;
    logic [31:0]   rs2_data;
    logic [4:0]    rs1_addr;
    logic [4:0]    rs2_addr;
    logic [4:0]    rd_out;
    issue_bundle_t issue;
    logic          hazard;

    row_t          rows[$];
    int            start_err[$];
    int            errors;
    int            failed_tests;
    logic          reset_ok;

    // Reference model of the issue register, replay copy and lock queue
    issue_bundle_t exp_issue;
    instr_t        held;
    logic          replay;
    logic [4:0]    lock0;
    logic [4:0]    lock1;

    always #2 clk = ~clk;

    decode_stage UUT (
        .clk        (clk),
        .reset      (reset),
        .stall_i    (stall),
        .killed_i   (killed),
        .jumped_i   (jumped),
        .fetch_i    (fetch),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .rs1_o      (rs1_addr),
        .rs2_o      (rs2_addr),
        .rd_o       (rd_out),
        .issue_o    (issue),
        .hazard_o   (hazard)
    );

    ////////////////////////////////////////////////////////////
    // Register file model
    ////////////////////////////////////////////////////////////
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // x0 always reads zero
    function automatic logic [31:0] reg_value(input logic [4:0] idx);
        logic [31:0] x;
        x = 32'h7b74;
        repeat (idx)
            x = xorshift(x);
        return (idx == 5'd0) ? 32'h0 : x;
    endfunction

    assign rs1_data = reg_value(rs1_addr);
    assign rs2_data = reg_value(rs2_addr);

    ////////////////////////////////////////////////////////////
    // Instruction encoders, immediate layouts per RV32I
    ////////////////////////////////////////////////////////////
    function automatic logic [31:0] itype_word(input logic [11:0] imm, input logic [4:0] rs1,
                                               input logic [2:0] f3, input logic [4:0] rd,
                                               input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] store_word(input logic [11:0] imm, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] branch_word(input logic [12:0] imm, input logic [4:0] rs2,
                                                input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] jal_word(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    task automatic add_row(input string name, input logic [31:0] instr, input logic [31:0] pc,
                           input logic [2:0] ctl, input iType_e op, input logic [31:0] a,
                           input logic [31:0] b, input logic [31:0] c, input logic [2:0] flags,
                           input logic haz);
        row_t r;
        r.name  = name;
        r.instr = instr;
        r.pc    = pc;
        r.stall = ctl[2];
        r.kill  = ctl[1];
        r.jump  = ctl[0];
        r.op    = op;
        r.a     = a;
        r.b     = b;
        r.c     = c;
        r.flags = flags;
        r.haz   = haz;
        rows.push_back(r);
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////////////////////////
    // Control column is {stall, kill, jump}
    // Flags column is {killed, illegal, misaligned}
    task automatic build_table();
        add_row("lui", {20'h12345, 5'd20, OPC_LUI}, 32'h100, 3'b000, LUI,
                32'h100, 32'h12345000, 32'h12345000, 3'b000, 1'b0);
        add_row("auipc", {20'hfffff, 5'd21, OPC_AUIPC}, 32'h104, 3'b000, ADD,
                32'h104, 32'hfffff000, 32'hfffff000, 3'b000, 1'b0);
        add_row("jal", jal_word(21'h1fffec, 5'd1), 32'h108, 3'b000, JAL,
                32'h108, 32'hffffffec, 32'hffffffec, 3'b000, 1'b0);
        add_row("jalr", itype_word(12'h010, 5'd2, 3'd0, 5'd22, OPC_JALR), 32'h10c, 3'b000, JALR,
                reg_value(5'd2), 32'h10, 32'h10, 3'b000, 1'b0);
        add_row("beq", branch_word(13'h1ff8, 5'd4, 5'd3, 3'd0), 32'h110, 3'b000, BEQ,
                reg_value(5'd3), reg_value(5'd4), 32'hfffffff8, 3'b000, 1'b0);
        add_row("lw", itype_word(12'hffc, 5'd7, 3'd2, 5'd23, OPC_LOAD), 32'h114, 3'b000, LW,
                reg_value(5'd7), 32'hfffffffc, 32'hfffffffc, 3'b000, 1'b0);
        add_row("sw", store_word(12'h028, 5'd8, 5'd9, 3'd2), 32'h118, 3'b000, SW,
                reg_value(5'd9), 32'h28, reg_value(5'd8), 3'b000, 1'b0);
        add_row("srai", itype_word(12'h403, 5'd10, 3'd5, 5'd24, OPC_OP_IMM), 32'h11c, 3'b000, SRA,
                reg_value(5'd10), 32'h403, 32'h403, 3'b000, 1'b0);
        add_row("sub", {FUNCT7_ALT, 5'd2, 5'd1, 3'd0, 5'd25, OPC_OP}, 32'h120, 3'b000, SUB,
                reg_value(5'd1), reg_value(5'd2), 32'h0, 3'b000, 1'b0);
        // Predecessor and successor bits land in the rs2 slot
        add_row("fence", itype_word(12'h0ff, 5'd0, 3'd0, 5'd0, OPC_MISC_MEM), 32'h124, 3'b000,
                NOP, 32'h0, reg_value(5'd31), 32'h0, 3'b000, 1'b0);
        add_row("ecall", 32'h00000073, 32'h128, 3'b000, ECALL,
                32'h0, 32'h0, 32'h0, 3'b000, 1'b0);
        add_row("mret", 32'h30200073, 32'h12c, 3'b000, MRET,
                32'h0, reg_value(5'd2), 32'h0, 3'b000, 1'b0);
        add_row("csrrsi", itype_word(12'h300, 5'd5, 3'd6, 5'd26, OPC_SYSTEM), 32'h130, 3'b000,
                CSRRSI, reg_value(5'd5), 32'h0, 32'h0, 3'b000, 1'b0);
        add_row("bad_opc", 32'h0000000b, 32'h134, 3'b000, INVALID,
                32'h0, 32'h0, 32'h0, 3'b010, 1'b0);
        add_row("bad_f7", {7'b0000001, 5'd3, 5'd4, 3'd0, 5'd27, OPC_OP}, 32'h138, 3'b000, INVALID,
                reg_value(5'd4), reg_value(5'd3), 32'h0, 3'b010, 1'b0);
        add_row("bad_sys", 32'h00200073, 32'h13c, 3'b000, INVALID,
                32'h0, reg_value(5'd2), 32'h0, 3'b010, 1'b0);
        // Read after write on x12
        add_row("addi_wr", itype_word(12'h005, 5'd1, 3'd0, 5'd12, OPC_OP_IMM), 32'h140, 3'b000,
                ADD, reg_value(5'd1), 32'h5, 32'h5, 3'b000, 1'b0);
        add_row("add_haz", {FUNCT7_BASE, 5'd3, 5'd12, 3'd0, 5'd13, OPC_OP}, 32'h144, 3'b000,
                NOP, 32'h0, 32'h0, 32'h0, 3'b000, 1'b1);
        add_row("replay", itype_word(12'h009, 5'd14, 3'd0, 5'd15, OPC_OP_IMM), 32'h148, 3'b000,
                ADD, reg_value(5'd12), reg_value(5'd3), 32'h0, 3'b000, 1'b0);
        add_row("wr_x0", itype_word(12'h001, 5'd2, 3'd0, 5'd0, OPC_OP_IMM), 32'h14c, 3'b000, ADD,
                reg_value(5'd2), 32'h1, 32'h1, 3'b000, 1'b0);
        add_row("rd_x0", {FUNCT7_BASE, 5'd0, 5'd0, 3'd6, 5'd16, OPC_OP}, 32'h150, 3'b000, OR,
                32'h0, 32'h0, 32'h0, 3'b000, 1'b0);
        // rs2 slot matches the lock but I format ignores it
        add_row("i_rs2", itype_word(12'h010, 5'd1, 3'd4, 5'd17, OPC_OP_IMM), 32'h154, 3'b000, XOR,
                reg_value(5'd1), 32'h10, 32'h10, 3'b000, 1'b0);
        add_row("stall", {FUNCT7_BASE, 5'd5, 5'd6, 3'd7, 5'd18, OPC_OP}, 32'h158, 3'b100, AND,
                reg_value(5'd6), reg_value(5'd5), 32'h0, 3'b000, 1'b0);
        add_row("stall_rel", {FUNCT7_BASE, 5'd5, 5'd6, 3'd7, 5'd18, OPC_OP}, 32'h158, 3'b000, AND,
                reg_value(5'd6), reg_value(5'd5), 32'h0, 3'b000, 1'b0);
        add_row("misalign", itype_word(12'h000, 5'd1, 3'd0, 5'd19, OPC_OP_IMM), 32'h15e, 3'b001,
                ADD, reg_value(5'd1), 32'h0, 32'h0, 3'b101, 1'b0);
        add_row("killed", {FUNCT7_BASE, 5'd2, 5'd1, 3'd0, 5'd20, OPC_OP}, 32'h164, 3'b010, ADD,
                reg_value(5'd1), reg_value(5'd2), 32'h0, 3'b100, 1'b0);
    endtask

    ////////////////////////////////////////////////////////////
    // Driving, model and checks
    ////////////////////////////////////////////////////////////
    task automatic drive_row(input row_t r);
        fetch.instruction <= r.instr;
        fetch.pc          <= r.pc;
        stall             <= r.stall;
        killed            <= r.kill;
        jumped            <= r.jump;
    endtask

    // One clock edge of the stage as the rules describe it
    task automatic update_model(input row_t r);
        instr_t eff;
        eff = replay ? held : r.instr;
        if (r.haz) begin
            exp_issue           = '0;
            exp_issue.operation = NOP;
        end else if (!r.stall) begin
            exp_issue.first_operand  = r.a;
            exp_issue.second_operand = r.b;
            exp_issue.third_operand  = r.c;
            exp_issue.pc             = r.pc;
            exp_issue.instruction    = eff;
            exp_issue.operation      = r.op;
            exp_issue.killed         = r.flags[2];
            exp_issue.exc_illegal    = r.flags[1];
            exp_issue.exc_misaligned = r.flags[0];
        end
        if (!r.stall) begin
            lock1 = lock0;
            lock0 = r.haz ? 5'd0 : eff.rd;
        end
        held   = eff;
        replay = r.haz;
    endtask

    task automatic check_value(input string test, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s %s expected %h actual %h", test, field, expected, actual);
            errors++;
        end
    endtask

    task automatic score_row(input row_t r, input int err_before);
        check_value(r.name, "operation", 32'(exp_issue.operation), 32'(issue.operation));
        check_value(r.name, "first_operand", exp_issue.first_operand, issue.first_operand);
        check_value(r.name, "second_operand", exp_issue.second_operand, issue.second_operand);
        check_value(r.name, "third_operand", exp_issue.third_operand, issue.third_operand);
        check_value(r.name, "pc", exp_issue.pc, issue.pc);
        check_value(r.name, "instruction", exp_issue.instruction, issue.instruction);
        check_value(r.name, "flags",
                    32'({exp_issue.killed, exp_issue.exc_illegal, exp_issue.exc_misaligned}),
                    32'({issue.killed, issue.exc_illegal, issue.exc_misaligned}));
        check_value(r.name, "rd", 32'(lock1), 32'(rd_out));
        if (errors == err_before) begin
            $display("test %-10s ok", r.name);
        end else begin
            $display("test %-10s failed", r.name);
            failed_tests++;
        end
    endtask

    // Bubble state with rd and hazard cleared
    task automatic wait_reset_state(output logic ok);
        int cycles;
        cycles = 0;
        ok     = 1'b1;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > 16) begin
                $display("Timeout: the DUT never showed its reset state");
                ok = 1'b0;
            end
        end while (ok && !(issue === '0 && rd_out === 5'd0 && hazard === 1'b0));
    endtask

    initial begin
        clk               = 1'b0;
        reset             = 1'b1;
        stall             = 1'b0;
        killed            = 1'b0;
        jumped            = 1'b0;
        fetch.instruction = RESET_WORD;
        fetch.pc          = 32'h0;
        errors            = 0;
        failed_tests      = 0;
        exp_issue         = '0;
        held              = RESET_WORD;
        replay            = 1'b0;
        lock0             = held.rd;
        lock1             = 5'd0;
        build_table();
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        wait_reset_state(reset_ok);
        if (reset_ok) begin
            // Hazard of a row is seen in its own cycle, its issue one edge later
            for (int i = 0; i <= rows.size(); i++) begin
                @(posedge clk);
                if (i > 0)
                    update_model(rows[i-1]);
                if (i < rows.size()) begin
                    drive_row(rows[i]);
                end else begin
                    fetch.instruction <= NOP_WORD;
                    stall             <= 1'b0;
                    killed            <= 1'b0;
                    jumped            <= 1'b0;
                end
                @(negedge clk);
                if (i > 0)
                    score_row(rows[i-1], start_err[i-1]);
                if (i < rows.size()) begin
                    start_err.push_back(errors);
                    check_value(rows[i].name, "hazard", 32'(rows[i].haz), 32'(hazard));
                end
            end
        end
        $display("%0d tests, %0d failed, %0d mismatches", rows.size(), failed_tests, errors);
        if (reset_ok && errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- files.f
logic/rv_isa_pkg.sv
logic/decode_pipe_pkg.sv
logic/instr_classifier.sv
logic/operand_router.sv
logic/hazard_unit.sv
logic/decode_stage.sv
verification/decode_stage_properties.sv
verification/decode_stage_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= decode_stage_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(BUILD_DIR)
